/* list.f */
+incdir+verilog
verilog/ahb_om_pkg.sv
verilog/port_mux.sv
verilog/output_arbiter.sv
verilog/data_phase_ctrl.sv
verilog/ahb_output_stage.sv
verification/tb_clock_gen.sv
verification/tb_ahb_output_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the output stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_ahb_output_stage \
  -f list.f

./obj_dir/Vtb_ahb_output_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  exit 1
fi
exit 0

/* verification/output_stage_patterns.txt */
# Columns: per port N=0..2 held sel trans burst mastlock, then hreadyoutm,
# expected active flags (bit0 = port 0) and expected granted port, all hex
# Single NONSEQ from port 1
0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 0 0
0 0 0 0 0  1 1 2 0 0  0 0 0 0 0  1 0 0
0 0 0 0 0  0 1 2 0 0  0 0 0 0 0  1 2 1
0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 0 1
# Round robin with all ports requesting
1 1 2 0 0  1 1 2 0 0  1 1 2 0 0  1 0 1
1 1 2 0 0  1 1 2 0 0  1 1 2 0 0  1 4 2
1 1 2 0 0  1 1 2 0 0  1 1 2 0 0  1 1 0
1 1 2 0 0  1 1 2 0 0  1 1 2 0 0  1 2 1
1 1 2 0 0  1 1 2 0 0  1 1 2 0 0  1 4 2
# Port 0 burst holds the grant
1 1 3 1 0  1 1 2 0 0  1 1 2 0 0  1 1 0
1 1 3 1 0  1 1 2 0 0  1 1 2 0 0  1 1 0
1 1 1 1 0  1 1 2 0 0  1 1 2 0 0  1 1 0
1 1 3 1 0  1 1 2 0 0  1 1 2 0 0  1 1 0
1 1 2 0 0  1 1 2 0 0  1 1 2 0 0  1 1 0
# Locked sequence on port 2 with a deselected beat
0 0 0 0 0  0 1 2 0 0  1 1 2 0 1  1 2 1
1 1 2 0 0  0 0 0 0 0  0 1 2 0 1  1 4 2
1 1 2 0 0  0 0 0 0 0  0 0 2 0 1  1 4 2
1 1 2 0 0  0 0 0 0 0  1 1 2 0 1  1 4 2
1 1 2 0 0  0 0 0 0 0  0 1 2 0 0  1 4 2
# Write data phase and slave wait states
0 1 2 0 0  1 1 2 0 0  0 0 0 0 0  1 1 0
0 0 0 0 0  1 1 2 0 0  1 1 2 0 0  0 2 1
0 0 0 0 0  1 1 2 0 0  1 1 2 0 0  0 2 1
0 0 0 0 0  0 1 2 0 0  1 1 2 0 0  1 2 1
0 0 0 0 0  0 0 0 0 0  0 1 2 0 0  1 4 2
0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 2
0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  1 0 2
0 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 2

/* verification/tb_ahb_output_stage.sv */
`timescale 1ns/1ps
`include "ahb_om_config.svh"

module tb_ahb_output_stage;

  localparam int MAX_PAT = 64;            // Room for pattern lines
  localparam int N_FLD   = 18;            // Fields per pattern line

  logic                     HCLK;
  logic                     HRESETn;

  // Per-port stimulus
  logic                     held     [3];
  logic                     sel      [3];
  logic [1:0]               trans    [3];
  logic [2:0]               burst    [3];
  logic                     mastlock [3];
  logic [`AHB_ADDR_W-1:0]   addr     [3];
  logic [`AHB_DATA_W-1:0]   wdata    [3];
  logic                     write    [3];
  logic [2:0]               size     [3];
  logic [3:0]               prot     [3];
  logic [`AHB_MASTER_W-1:0] master   [3];
  logic                     hreadyoutm;

  logic                     active_op0, active_op1, active_op2;
  logic                     hselm, hwritem, hmastlockm, hreadymuxm;
  logic [`AHB_ADDR_W-1:0]   haddrm;
  logic [1:0]               htransm;
  logic [2:0]               hsizem, hburstm;
  logic [3:0]               hprotm;
  logic [`AHB_MASTER_W-1:0] hmasterm;
  logic [`AHB_DATA_W-1:0]   hwdatam;

  int          pat [MAX_PAT][N_FLD];      // Loaded pattern table
  int          n_pat;
  bit          loaded;
  int          err_count;
  int          check_count;
  logic [31:0] lfsr_state;

  // Reference model of the data phase
  int          exp_dport;
  logic        exp_ssel;

  tb_clock_gen u_clk (
    .HCLK    (HCLK),
    .HRESETn (HRESETn)
  );

  ahb_output_stage uut (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .i_sel_op0 (sel[0]), .i_addr_op0 (addr[0]), .i_trans_op0 (trans[0]),
    .i_write_op0 (write[0]), .i_size_op0 (size[0]), .i_burst_op0 (burst[0]),
    .i_prot_op0 (prot[0]), .i_master_op0 (master[0]), .i_mastlock_op0 (mastlock[0]),
    .i_wdata_op0 (wdata[0]), .i_held_tran_op0 (held[0]),
    .i_sel_op1 (sel[1]), .i_addr_op1 (addr[1]), .i_trans_op1 (trans[1]),
    .i_write_op1 (write[1]), .i_size_op1 (size[1]), .i_burst_op1 (burst[1]),
    .i_prot_op1 (prot[1]), .i_master_op1 (master[1]), .i_mastlock_op1 (mastlock[1]),
    .i_wdata_op1 (wdata[1]), .i_held_tran_op1 (held[1]),
    .i_sel_op2 (sel[2]), .i_addr_op2 (addr[2]), .i_trans_op2 (trans[2]),
    .i_write_op2 (write[2]), .i_size_op2 (size[2]), .i_burst_op2 (burst[2]),
    .i_prot_op2 (prot[2]), .i_master_op2 (master[2]), .i_mastlock_op2 (mastlock[2]),
    .i_wdata_op2 (wdata[2]), .i_held_tran_op2 (held[2]),
    .i_hreadyoutm (hreadyoutm),
    .o_active_op0 (active_op0), .o_active_op1 (active_op1), .o_active_op2 (active_op2),
    .o_hselm (hselm), .o_haddrm (haddrm), .o_htransm (htransm), .o_hwritem (hwritem),
    .o_hsizem (hsizem), .o_hburstm (hburstm), .o_hprotm (hprotm),
    .o_hmasterm (hmasterm), .o_hmastlockm (hmastlockm),
    .o_hreadymuxm (hreadymuxm), .o_hwdatam (hwdatam)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v          = {v[30:0], lfsr_state[31]};  // One step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp)
    else
    begin
      err_count++;
      $display("error %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic load_patterns();
    int    fd;
    int    cnt;
    int    f [N_FLD];
    string line;
    fd = $fopen("verification/output_stage_patterns.txt", "r");
    if (fd == 0)
    begin
      err_count++;
      $display("Could not open the pattern file");
    end
    else
    begin
      while (!$feof(fd) && n_pat < MAX_PAT)
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#")
        begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
          if (cnt == N_FLD)
          begin
            for (int k = 0; k < N_FLD; k++)
              pat[n_pat][k] = f[k];
            n_pat++;
          end
        end
      end
      $fclose(fd);
      if (n_pat == 0)
      begin
        err_count++;
        $display("The pattern file holds no pattern lines");
      end
    end
  endtask

  // Puts one pattern line and fresh random payloads on the ports
  task automatic drive_line(input int idx);
    logic [31:0] v;
    for (int p = 0; p < 3; p++)
    begin
      held[p]     = pat[idx][p*5];
      sel[p]      = pat[idx][p*5+1];
      trans[p]    = pat[idx][p*5+2];
      burst[p]    = pat[idx][p*5+3];
      mastlock[p] = pat[idx][p*5+4];
      take_bits(32, v);
      addr[p]     = v;
      take_bits(32, v);
      wdata[p]    = v;
      take_bits(1, v);
      write[p]    = v[0];
      take_bits(3, v);
      size[p]     = v[2:0];
      take_bits(4, v);
      prot[p]     = v[3:0];
      take_bits(4, v);
      master[p]   = v[3:0];
    end
    hreadyoutm = pat[idx][15];
  endtask

  task automatic check_line(input int idx);
    logic [2:0] act;
    int         gp;
    logic       exp_rdy;
    act     = pat[idx][16];
    gp      = pat[idx][17];
    exp_rdy = exp_ssel ? hreadyoutm : 1'b1;  // Slave ready only in its data phase
    check_value("o_active_op0", active_op0, act[0]);
    check_value("o_active_op1", active_op1, act[1]);
    check_value("o_active_op2", active_op2, act[2]);
    check_value("o_hreadymuxm", hreadymuxm, exp_rdy);
    check_value("o_hwdatam", hwdatam, wdata[exp_dport]);
    if (act != 3'b000)
    begin
      check_value("o_hselm", hselm, sel[gp]);
      check_value("o_haddrm", haddrm, addr[gp]);
      check_value("o_htransm", htransm, trans[gp]);
      check_value("o_hwritem", hwritem, write[gp]);
      check_value("o_hsizem", hsizem, size[gp]);
      check_value("o_hburstm", hburstm, burst[gp]);
      check_value("o_hprotm", hprotm, prot[gp]);
      check_value("o_hmasterm", hmasterm, master[gp]);
      check_value("o_hmastlockm", hmastlockm, mastlock[gp]);
    end
    else
    begin
      check_value("o_hselm", hselm, 1'b0);
      check_value("o_htransm", htransm, 2'b00);  // IDLE without a grant
    end
    // Address phase moves into the data phase on a ready edge
    if (exp_rdy)
    begin
      exp_dport = gp;
      exp_ssel  = (act != 3'b000) ? sel[gp] : 1'b0;
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial
  begin
    for (int p = 0; p < 3; p++)
    begin
      held[p]     = 0;
      sel[p]      = 0;
      trans[p]    = 0;
      burst[p]    = 0;
      mastlock[p] = 0;
      addr[p]     = 0;
      wdata[p]    = 0;
      write[p]    = 0;
      size[p]     = 0;
      prot[p]     = 0;
      master[p]   = 0;
    end
    hreadyoutm  = 1'b1;
    lfsr_state  = 32'd71446;
    err_count   = 0;
    check_count = 0;
    n_pat       = 0;
    exp_dport   = 0;
    exp_ssel    = 1'b0;
    load_patterns();
    loaded = 1'b1;

    // Idle outputs during reset
    repeat (4)
    begin
      @(posedge HCLK);
      #6;
      check_value("o_active_op0", active_op0, 1'b0);
      check_value("o_active_op1", active_op1, 1'b0);
      check_value("o_active_op2", active_op2, 1'b0);
      check_value("o_hselm", hselm, 1'b0);
      check_value("o_htransm", htransm, 2'b00);
      check_value("o_hreadymuxm", hreadymuxm, 1'b1);
    end

    for (int i = 0; i < n_pat; i++)
    begin
      @(posedge HCLK);
      #1 drive_line(i);
      #5 check_line(i);   // Sampled well before the next edge
    end

    $display("Checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // Watchdog sized from the pattern count
  initial
  begin
    int limit_ns;
    wait (loaded);
    limit_ns = (n_pat + 4 + 16) * 8;
    #(limit_ns);
    $display("Watchdog timeout: run exceeded %0d ns", limit_ns);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic HCLK,      // 8 ns AHB clock
  output logic HRESETn    // Sync reset, active low
);

  initial
  begin
    HCLK = 1'b0;
  end

  always #4 HCLK = ~HCLK;  // Half period

  // Reset held over four rising edges
  initial
  begin
    HRESETn = 1'b0;
    repeat (4) @(posedge HCLK);
    #1 HRESETn = 1'b1;    // Released off the edge
  end

endmodule

/* verilog/ahb_om_config.svh */
`ifndef AHB_OM_CONFIG_SVH
`define AHB_OM_CONFIG_SVH

// ----------------------------------------------------------------------
// Output stage bus widths
// ----------------------------------------------------------------------

`define AHB_ADDR_W    32          // HADDR width
`define AHB_DATA_W    32          // HWDATA width
`define AHB_MASTER_W  4           // HMASTER width

// ----------------------------------------------------------------------
// Bus matrix geometry
// ----------------------------------------------------------------------

// Input stages that can reach this slave
`define OM_NUM_PORTS  3

`endif

/* verilog/ahb_om_pkg.sv */
`include "ahb_om_config.svh"

package ahb_om_pkg;

  // Input stage number, wide enough for every port
  typedef logic [$clog2(`OM_NUM_PORTS)-1:0] port_idx_t;

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,          // No transfer
    HTRANS_BUSY   = 2'b01,          // Burst paused
    HTRANS_NONSEQ = 2'b10,          // First beat
    HTRANS_SEQ    = 2'b11           // Burst continues
  } htrans_t;

  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001,         // Undefined length
    HBURST_WRAP4  = 3'b010,
    HBURST_INCR4  = 3'b011,
    HBURST_WRAP8  = 3'b100,
    HBURST_INCR8  = 3'b101,
    HBURST_WRAP16 = 3'b110,
    HBURST_INCR16 = 3'b111
  } hburst_t;

  typedef struct packed {
    logic                     sel;       // HSEL for this slave
    logic [`AHB_ADDR_W-1:0]   addr;      // HADDR
    htrans_t                  trans;     // HTRANS
    logic                     write;     // HWRITE
    logic [2:0]               size;      // HSIZE
    hburst_t                  burst;     // HBURST
    logic [3:0]               prot;      // HPROT
    logic [`AHB_MASTER_W-1:0] master;    // HMASTER
    logic                     mastlock;  // HMASTLOCK
  } addr_phase_t;

  typedef struct packed {
    logic [`AHB_DATA_W-1:0]   wdata;     // HWDATA
  } data_phase_t;

endpackage

/* verilog/ahb_output_stage.sv */
`timescale 1ns/1ps
`include "ahb_om_config.svh"

module ahb_output_stage (
  input  logic                     HCLK,             // AHB clock
  input  logic                     HRESETn,          // Sync reset, active low
  // Input stage 0
  input  logic                     i_sel_op0,
  input  logic [`AHB_ADDR_W-1:0]   i_addr_op0,
  input  logic [1:0]               i_trans_op0,
  input  logic                     i_write_op0,
  input  logic [2:0]               i_size_op0,
  input  logic [2:0]               i_burst_op0,
  input  logic [3:0]               i_prot_op0,
  input  logic [`AHB_MASTER_W-1:0] i_master_op0,
  input  logic                     i_mastlock_op0,
  input  logic [`AHB_DATA_W-1:0]   i_wdata_op0,
  input  logic                     i_held_tran_op0,  // Transfer pending
  // Input stage 1
  input  logic                     i_sel_op1,
  input  logic [`AHB_ADDR_W-1:0]   i_addr_op1,
  input  logic [1:0]               i_trans_op1,
  input  logic                     i_write_op1,
  input  logic [2:0]               i_size_op1,
  input  logic [2:0]               i_burst_op1,
  input  logic [3:0]               i_prot_op1,
  input  logic [`AHB_MASTER_W-1:0] i_master_op1,
  input  logic                     i_mastlock_op1,
  input  logic [`AHB_DATA_W-1:0]   i_wdata_op1,
  input  logic                     i_held_tran_op1,
  // Input stage 2
  input  logic                     i_sel_op2,
  input  logic [`AHB_ADDR_W-1:0]   i_addr_op2,
  input  logic [1:0]               i_trans_op2,
  input  logic                     i_write_op2,
  input  logic [2:0]               i_size_op2,
  input  logic [2:0]               i_burst_op2,
  input  logic [3:0]               i_prot_op2,
  input  logic [`AHB_MASTER_W-1:0] i_master_op2,
  input  logic                     i_mastlock_op2,
  input  logic [`AHB_DATA_W-1:0]   i_wdata_op2,
  input  logic                     i_held_tran_op2,
  input  logic                     i_hreadyoutm,     // Slave HREADYOUT
  // Grant indication back to input stages
  output logic                     o_active_op0,
  output logic                     o_active_op1,
  output logic                     o_active_op2,
  // Shared slave
  output logic                     o_hselm,
  output logic [`AHB_ADDR_W-1:0]   o_haddrm,
  output logic [1:0]               o_htransm,
  output logic                     o_hwritem,
  output logic [2:0]               o_hsizem,
  output logic [2:0]               o_hburstm,
  output logic [3:0]               o_hprotm,
  output logic [`AHB_MASTER_W-1:0] o_hmasterm,
  output logic                     o_hmastlockm,
  output logic                     o_hreadymuxm,
  output logic [`AHB_DATA_W-1:0]   o_hwdatam
);

  ahb_om_pkg::addr_phase_t  addr_ph0, addr_ph1, addr_ph2;  // Per-port address phase
  ahb_om_pkg::data_phase_t  data_ph0, data_ph1, data_ph2;  // Per-port write data
  ahb_om_pkg::addr_phase_t  addr_m;                        // Routed address phase
  ahb_om_pkg::data_phase_t  wdata_m;                       // Routed write data
  ahb_om_pkg::port_idx_t    addr_in_port;
  logic                     no_port;
  logic                     hreadymux;
  logic [`OM_NUM_PORTS-1:0] req;

  // ----------------------------------------------------------------------
  // Payload packing
  // ----------------------------------------------------------------------

  assign addr_ph0 = '{sel: i_sel_op0, addr: i_addr_op0,
                      trans: ahb_om_pkg::htrans_t'(i_trans_op0), write: i_write_op0,
                      size: i_size_op0, burst: ahb_om_pkg::hburst_t'(i_burst_op0),
                      prot: i_prot_op0, master: i_master_op0, mastlock: i_mastlock_op0};
  assign addr_ph1 = '{sel: i_sel_op1, addr: i_addr_op1,
                      trans: ahb_om_pkg::htrans_t'(i_trans_op1), write: i_write_op1,
                      size: i_size_op1, burst: ahb_om_pkg::hburst_t'(i_burst_op1),
                      prot: i_prot_op1, master: i_master_op1, mastlock: i_mastlock_op1};
  assign addr_ph2 = '{sel: i_sel_op2, addr: i_addr_op2,
                      trans: ahb_om_pkg::htrans_t'(i_trans_op2), write: i_write_op2,
                      size: i_size_op2, burst: ahb_om_pkg::hburst_t'(i_burst_op2),
                      prot: i_prot_op2, master: i_master_op2, mastlock: i_mastlock_op2};

  assign data_ph0 = '{wdata: i_wdata_op0};
  assign data_ph1 = '{wdata: i_wdata_op1};
  assign data_ph2 = '{wdata: i_wdata_op2};

  // Request needs both a pending transfer and this slave selected
  assign req = {i_held_tran_op2 & i_sel_op2,
                i_held_tran_op1 & i_sel_op1,
                i_held_tran_op0 & i_sel_op0};

  // ----------------------------------------------------------------------
  // Arbitration and routing
  // ----------------------------------------------------------------------

  output_arbiter u_output_arb (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_req          (req),
    .i_hready       (hreadymux),
    .i_sel_m        (addr_m.sel),
    .i_trans_m      (addr_m.trans),
    .i_mastlock_m   (addr_m.mastlock),
    .o_addr_in_port (addr_in_port),
    .o_no_port      (no_port)
  );

  port_mux #(
    .payload_t (ahb_om_pkg::addr_phase_t)
  ) u_addr_mux (
    .i_in0  (addr_ph0),
    .i_in1  (addr_ph1),
    .i_in2  (addr_ph2),
    .i_port (addr_in_port),
    .i_en   (~no_port),          // IDLE and deselected with no grant
    .o_out  (addr_m)
  );

  data_phase_ctrl u_data_ctrl (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_addr_in_port (addr_in_port),
    .i_sel_m        (addr_m.sel),
    .i_hreadyoutm   (i_hreadyoutm),
    .i_wdata0       (data_ph0),
    .i_wdata1       (data_ph1),
    .i_wdata2       (data_ph2),
    .o_hreadymux    (hreadymux),
    .o_wdata        (wdata_m)
  );

  // Slave side
  assign o_hselm      = addr_m.sel;
  assign o_haddrm     = addr_m.addr;
  assign o_htransm    = addr_m.trans;
  assign o_hwritem    = addr_m.write;
  assign o_hsizem     = addr_m.size;
  assign o_hburstm    = addr_m.burst;
  assign o_hprotm     = addr_m.prot;
  assign o_hmasterm   = addr_m.master;
  assign o_hmastlockm = addr_m.mastlock;
  assign o_hreadymuxm = hreadymux;
  assign o_hwdatam    = wdata_m.wdata;

  // Active flags decoded from the grant
  always_comb
  begin : p_active_dec
    o_active_op0 = 1'b0;
    o_active_op1 = 1'b0;
    o_active_op2 = 1'b0;
    if (!no_port)
    begin
      case (addr_in_port)
        ahb_om_pkg::port_idx_t'(0) : o_active_op0 = 1'b1;
        ahb_om_pkg::port_idx_t'(1) : o_active_op1 = 1'b1;
        ahb_om_pkg::port_idx_t'(2) : o_active_op2 = 1'b1;
        default : o_active_op0 = 1'b0;  // Never granted
      endcase
    end
  end

endmodule

/* verilog/data_phase_ctrl.sv */
`timescale 1ns/1ps

module data_phase_ctrl (
  input  logic                    HCLK,            // AHB clock
  input  logic                    HRESETn,         // Sync reset, active low
  input  ahb_om_pkg::port_idx_t   i_addr_in_port,  // Address phase owner
  input  logic                    i_sel_m,         // Selected HSEL
  input  logic                    i_hreadyoutm,    // Slave HREADYOUT
  input  ahb_om_pkg::data_phase_t i_wdata0,        // Port 0 write data
  input  ahb_om_pkg::data_phase_t i_wdata1,        // Port 1 write data
  input  ahb_om_pkg::data_phase_t i_wdata2,        // Port 2 write data
  output logic                    o_hreadymux,     // HREADYMUXM
  output ahb_om_pkg::data_phase_t o_wdata          // HWDATAM payload
);

  ahb_om_pkg::port_idx_t data_in_port;   // Data phase owner
  logic                  slave_sel;      // Slave in data phase
  logic                  hreadymux;

  // ----------------------------------------------------------------------
  // Data phase registers
  // ----------------------------------------------------------------------

  always_ff @(posedge HCLK)
  begin : p_data_reg
    if (!HRESETn)
    begin
      data_in_port <= '0;
      slave_sel    <= 1'b0;
    end
    else if (hreadymux)
    begin
      data_in_port <= i_addr_in_port;  // Address phase moves to data phase
      slave_sel    <= i_sel_m;
    end
  end

  // Slave drives ready only when it owns the data phase
  assign hreadymux = slave_sel ? i_hreadyoutm : 1'b1;

  // Write data follows the data phase owner
  port_mux #(
    .payload_t (ahb_om_pkg::data_phase_t)
  ) u_data_mux (
    .i_in0  (i_wdata0),
    .i_in1  (i_wdata1),
    .i_in2  (i_wdata2),
    .i_port (data_in_port),
    .i_en   (1'b1),                    // Always routed
    .o_out  (o_wdata)
  );

  assign o_hreadymux = hreadymux;

endmodule

/* verilog/output_arbiter.sv */
`timescale 1ns/1ps
`include "ahb_om_config.svh"

module output_arbiter (
  input  logic                       HCLK,            // AHB clock
  input  logic                       HRESETn,         // Sync reset, active low
  input  logic [`OM_NUM_PORTS-1:0]   i_req,           // Held transfer and select
  input  logic                       i_hready,        // HREADYMUXM feedback
  input  logic                       i_sel_m,         // Selected HSEL
  input  ahb_om_pkg::htrans_t        i_trans_m,       // Selected HTRANS
  input  logic                       i_mastlock_m,    // Selected HMASTLOCK
  output ahb_om_pkg::port_idx_t      o_addr_in_port,  // Granted address port
  output logic                       o_no_port        // Nothing granted
);

  // ----------------------------------------------------------------------
  // State and next-state signals
  // ----------------------------------------------------------------------

  ahb_om_pkg::port_idx_t addr_in_port;     // Current grant
  ahb_om_pkg::port_idx_t rr_ptr;           // Last port granted
  ahb_om_pkg::port_idx_t rr_pick;          // Next requester after rr_ptr
  ahb_om_pkg::port_idx_t next_port;        // Grant for next address phase
  logic                  no_port;          // Idle grant
  logic                  next_no_port;
  logic                  hsel_lock;        // Locked sequence under way
  logic                  next_hsel_lock;
  logic                  lock_arb;         // HMASTLOCK masked by select
  logic                  burst_cont;       // BUSY or SEQ beat
  logic                  active_beat;      // NONSEQ or SEQ beat
  logic                  hold_grant;       // Keep current port
  logic                  any_req;          // Some port wants the slave

  // ----------------------------------------------------------------------
  // Hold conditions
  // ----------------------------------------------------------------------

  assign burst_cont  = (i_trans_m == ahb_om_pkg::HTRANS_BUSY) |
                       (i_trans_m == ahb_om_pkg::HTRANS_SEQ);      // Mid burst
  assign active_beat = (i_trans_m == ahb_om_pkg::HTRANS_NONSEQ) |
                       (i_trans_m == ahb_om_pkg::HTRANS_SEQ);      // Real transfer

  // Lock still counts while the master briefly addresses another slave
  assign lock_arb = i_mastlock_m & (i_sel_m | hsel_lock);

  // A lock keeps the slave even when the port stops requesting here
  assign hold_grant = ~no_port & (lock_arb | (i_req[addr_in_port] & burst_cont));

  assign any_req = |i_req;

  // Locked-sequence tracking
  assign next_hsel_lock = (i_sel_m & active_beat & i_mastlock_m) ? 1'b1 :  // Lock begins
                          (~i_mastlock_m)                       ? 1'b0 :  // Lock ends
                          hsel_lock;                                      // Unchanged

  // ----------------------------------------------------------------------
  // Round-robin search
  // ----------------------------------------------------------------------

  always_comb
  begin : p_rr_pick
    int idx;                                       // Candidate port number
    rr_pick = rr_ptr;                              // No requester found
    // Walk backwards so the nearest port after rr_ptr wins
    for (int step = `OM_NUM_PORTS; step >= 1; step--)
    begin
      idx = (int'(rr_ptr) + step) % `OM_NUM_PORTS; // Wraps from 2 to 0
      if (i_req[idx])
        rr_pick = ahb_om_pkg::port_idx_t'(idx);
    end
  end

  always_comb
  begin : p_next_grant
    if (hold_grant)
    begin
      next_port    = addr_in_port;                 // Burst or lock continues
      next_no_port = 1'b0;
    end
    else if (any_req)
    begin
      next_port    = rr_pick;                      // Hand over to next requester
      next_no_port = 1'b0;
    end
    else
    begin
      next_port    = addr_in_port;                 // Keep last port number
      next_no_port = 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Grant registers, updated on HREADY edges only
  // ----------------------------------------------------------------------

  always_ff @(posedge HCLK)
  begin : p_grant_reg
    if (!HRESETn)
    begin
      addr_in_port <= '0;
      no_port      <= 1'b1;                                     // Idle out of reset
      rr_ptr       <= ahb_om_pkg::port_idx_t'(`OM_NUM_PORTS - 1); // Port 0 first
      hsel_lock    <= 1'b0;
    end
    else if (i_hready)
    begin
      addr_in_port <= next_port;
      no_port      <= next_no_port;
      hsel_lock    <= next_hsel_lock;
      if (!next_no_port)
        rr_ptr <= next_port;                                    // Remember last grant
    end
  end

  assign o_addr_in_port = addr_in_port;
  assign o_no_port      = no_port;

endmodule

/* verilog/port_mux.sv */
`timescale 1ns/1ps

module port_mux #(
  parameter type payload_t = logic         // Payload routed from a port
) (
  input  payload_t              i_in0,     // Port 0 payload
  input  payload_t              i_in1,     // Port 1 payload
  input  payload_t              i_in2,     // Port 2 payload
  input  ahb_om_pkg::port_idx_t i_port,    // Chosen port
  input  logic                  i_en,      // Selection valid
  output payload_t              o_out      // Routed payload
);

  // ----------------------------------------------------------------------
  // Payload selection
  // ----------------------------------------------------------------------

  always_comb
  begin : p_sel
    o_out = '0;                            // Quiet bus by default
    if (i_en)
    begin
      case (i_port)
        ahb_om_pkg::port_idx_t'(0) :
          o_out = i_in0;                   // Input stage 0
        ahb_om_pkg::port_idx_t'(1) :
          o_out = i_in1;                   // Input stage 1
        ahb_om_pkg::port_idx_t'(2) :
          o_out = i_in2;                   // Input stage 2
        default :
          o_out = '0;                      // Unused code
      endcase
    end
  end

endmodule
